/* verilog/rv_cpu_pkg.sv */
// --------------------
// shared types of the rv32i subset core, word accesses only
// opcode values follow the base rv32i encoding
// --------------------
package rv_cpu_pkg;

    localparam int xlen_c       = 32; // data path width
    localparam int reg_addr_w_c = 5;  // register index width

    typedef logic [xlen_c-1:0]       word_t;     // data, address, pc
    typedef logic [reg_addr_w_c-1:0] reg_addr_t; // register index

    // major opcodes --------
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111, // load upper immediate
        op_imm    = 7'b0010011, // reg-imm alu ops
        op_reg    = 7'b0110011, // reg-reg alu ops
        op_load   = 7'b0000011, // lw
        op_store  = 7'b0100011, // sw
        op_branch = 7'b1100011, // beq, bne
        op_jal    = 7'b1101111  // jump and link
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add, // sum
        alu_sub, // difference
        alu_and,
        alu_or,
        alu_xor,
        alu_slt  // signed less than
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu, // alu result
        wb_mem, // load data
        wb_pc4  // return address
    } wb_sel_e;

    typedef enum logic [1:0] {
        st_fetch,   // instruction bus request
        st_execute, // one cycle
        st_memory,  // data bus request
        st_sleep    // parked after jal to self
    } ctrl_state_e;

    // main control bus --------
    typedef struct packed {
        logic      rf_we;       // register write strobe
        wb_sel_e   wb_sel;      // write-back source
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        alu_op_e   alu_op;
        logic      alu_use_imm; // operand b = imm
        logic      alu_use_pc;  // operand a = pc
        logic      lsu_re;      // start load
        logic      lsu_we;      // start store
    } ctrl_bus_t;

endpackage

/* verilog/rv_cpu_regfile.sv */
// --------------------
// 32 x 32 register file, x0 reads as zero
// --------------------
module rv_cpu_regfile (
    input  logic                  clk_i,
    input  rv_cpu_pkg::ctrl_bus_t ctrl_i, // main control bus
    input  rv_cpu_pkg::word_t     alu_i,  // alu result
    input  rv_cpu_pkg::word_t     mem_i,  // load data
    input  rv_cpu_pkg::word_t     pc4_i,  // return address
    output rv_cpu_pkg::word_t     rs1_o,
    output rv_cpu_pkg::word_t     rs2_o
);
    rv_cpu_pkg::word_t rf_mem [0:31]; // register storage
    rv_cpu_pkg::word_t wb_data;       // write-back word

    always_comb begin
        case (ctrl_i.wb_sel)
            rv_cpu_pkg::wb_mem: wb_data = mem_i;
            rv_cpu_pkg::wb_pc4: wb_data = pc4_i;
            default:            wb_data = alu_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.rf_we) begin
            rf_mem[ctrl_i.rd_addr] <= wb_data; // x0 entry never read
        end
    end

    // async read ports, x0 forced to zero
    assign rs1_o = (ctrl_i.rs1_addr == '0) ? '0 : rf_mem[ctrl_i.rs1_addr];
    assign rs2_o = (ctrl_i.rs2_addr == '0) ? '0 : rf_mem[ctrl_i.rs2_addr];

endmodule

/* verilog/rv_cpu_alu.sv */
// --------------------
// combinational alu, no shifts, slt is signed only
// --------------------
module rv_cpu_alu (
    input  rv_cpu_pkg::ctrl_bus_t ctrl_i, // main control bus
    input  rv_cpu_pkg::word_t     rs1_i,
    input  rv_cpu_pkg::word_t     rs2_i,
    input  rv_cpu_pkg::word_t     pc_i,   // current pc
    input  rv_cpu_pkg::word_t     imm_i,
    output rv_cpu_pkg::word_t     res_o,  // operation result
    output rv_cpu_pkg::word_t     add_o,  // address / target sum
    output logic                  eq_o    // branch compare
);
    rv_cpu_pkg::word_t opa;  // rs1 or pc
    rv_cpu_pkg::word_t opb;  // rs2 or imm
    rv_cpu_pkg::word_t sum;  // opa + opb
    rv_cpu_pkg::word_t diff; // opa - opb

    // operand select --------
    assign opa  = ctrl_i.alu_use_pc ? pc_i : rs1_i;
    assign opb  = ctrl_i.alu_use_imm ? imm_i : rs2_i;

    assign sum  = opa + opb;
    assign diff = opa - opb;

    // operations --------
    always_comb begin
        case (ctrl_i.alu_op)
            rv_cpu_pkg::alu_sub: res_o = diff;
            rv_cpu_pkg::alu_and: res_o = opa & opb;
            rv_cpu_pkg::alu_or:  res_o = opa | opb;
            rv_cpu_pkg::alu_xor: res_o = opa ^ opb;
            rv_cpu_pkg::alu_slt: res_o = {31'b0, $signed(opa) < $signed(opb)};
            default:             res_o = sum; // add, lui
        endcase
    end

    assign add_o = sum;             // lw/sw address, branch and jal target
    assign eq_o  = (rs1_i == rs2_i); // beq / bne

endmodule

/* verilog/rv_cpu_lsu.sv */
// --------------------
// word-only data bus unit, no byte enables and no bus errors
// request held until ack, acks with nothing pending are ignored
// --------------------
module rv_cpu_lsu (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  rv_cpu_pkg::ctrl_bus_t ctrl_i,  // main control bus
    input  rv_cpu_pkg::word_t     addr_i,  // rs1 + imm
    input  rv_cpu_pkg::word_t     wdata_i, // rs2
    output rv_cpu_pkg::word_t     rdata_o, // load data
    output logic                  wait_o,  // access not yet acked
    // data bus
    output rv_cpu_pkg::word_t     d_bus_addr_o,
    input  rv_cpu_pkg::word_t     d_bus_rdata_i,
    output rv_cpu_pkg::word_t     d_bus_wdata_o,
    output logic                  d_bus_we_o,
    output logic                  d_bus_re_o,
    input  logic                  d_bus_ack_i
);
    rv_cpu_pkg::word_t addr_q;  // held address
    rv_cpu_pkg::word_t wdata_q; // held store data
    rv_cpu_pkg::word_t rdata_q; // captured load data
    logic              re_q;    // read pending
    logic              we_q;    // write pending
    logic              start;   // new access from execute
    logic              rd_ack;  // load completes now

    assign start  = ctrl_i.lsu_re | ctrl_i.lsu_we;
    assign rd_ack = re_q & d_bus_ack_i;

    // request handshake --------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            re_q <= 1'b0;
            we_q <= 1'b0;
        end else if (start) begin
            re_q <= ctrl_i.lsu_re;
            we_q <= ctrl_i.lsu_we;
        end else if (d_bus_ack_i) begin
            re_q <= 1'b0; // drop after ack
            we_q <= 1'b0;
        end
    end

    // address, data and load capture --------
    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if (rd_ack) begin
            rdata_q <= d_bus_rdata_i;
        end
    end

    assign rdata_o = rd_ack ? d_bus_rdata_i : rdata_q; // live in ack cycle
    assign wait_o  = (re_q | we_q) & ~d_bus_ack_i;

    assign d_bus_addr_o  = addr_q;
    assign d_bus_wdata_o = wdata_q;
    assign d_bus_re_o    = re_q;
    assign d_bus_we_o    = we_q;

endmodule

/* verilog/rv_cpu_control.sv */
// --------------------
// fetch / execute / memory fsm, unknown opcodes run as no-ops
// only beq and bne branch, other branch funct3 values fall through
// --------------------
module rv_cpu_control #(
    parameter rv_cpu_pkg::word_t cpu_boot_addr = '0
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    output rv_cpu_pkg::ctrl_bus_t ctrl_o,        // to rf, alu, lsu
    output rv_cpu_pkg::word_t     i_bus_addr_o,  // fetch address
    input  rv_cpu_pkg::word_t     i_bus_rdata_i, // instruction word
    output logic                  i_bus_re_o,
    input  logic                  i_bus_ack_i,
    input  logic                  eq_i,          // rs1 == rs2
    input  rv_cpu_pkg::word_t     alu_add_i,     // branch / jump target
    input  logic                  lsu_wait_i,    // data access pending
    output rv_cpu_pkg::word_t     imm_o,
    output rv_cpu_pkg::word_t     curr_pc_o,
    output rv_cpu_pkg::word_t     next_pc_o,     // return address
    output logic                  sleep_o
);
    rv_cpu_pkg::ctrl_state_e state_q;
    rv_cpu_pkg::word_t       pc_q;       // pc of instr in ir_q
    rv_cpu_pkg::word_t       pc_nxt;     // pc after execute
    rv_cpu_pkg::word_t       ir_q;       // instruction register
    rv_cpu_pkg::alu_op_e     func_op;    // funct3 decode
    logic                    i_re_q;     // fetch request
    logic                    func_ok;    // supported funct3
    logic                    reg_f7_ok;  // supported funct7
    logic                    exec;       // execute cycle
    logic                    mem_done;   // data access acked
    logic                    is_mem;     // lw or sw
    logic                    jal_self;   // jump to own address
    logic [2:0]              funct3;

    assign funct3    = ir_q[14:12];
    assign exec      = (state_q == rv_cpu_pkg::st_execute);
    assign mem_done  = (state_q == rv_cpu_pkg::st_memory) && !lsu_wait_i;
    assign reg_f7_ok = (ir_q[31:25] == 7'b0) || ((ir_q[31:25] == 7'b0100000) && (funct3 == 3'b000));

    // funct3 decode --------
    always_comb begin
        func_ok = 1'b1;
        func_op = rv_cpu_pkg::alu_add;
        case (funct3)
            3'b000:  func_op = ((ir_q[6:0] == rv_cpu_pkg::op_reg) && ir_q[30]) ?
                               rv_cpu_pkg::alu_sub : rv_cpu_pkg::alu_add; // bit 30 only for reg ops
            3'b010:  func_op = rv_cpu_pkg::alu_slt;
            3'b100:  func_op = rv_cpu_pkg::alu_xor;
            3'b110:  func_op = rv_cpu_pkg::alu_or;
            3'b111:  func_op = rv_cpu_pkg::alu_and;
            default: func_ok = 1'b0; // shifts, sltu not built
        endcase
    end

    // control bus and immediate --------
    always_comb begin
        ctrl_o          = '0;
        ctrl_o.rs1_addr = ir_q[19:15];
        ctrl_o.rs2_addr = ir_q[24:20];
        ctrl_o.rd_addr  = ir_q[11:7];
        ctrl_o.wb_sel   = rv_cpu_pkg::wb_alu;
        ctrl_o.alu_op   = rv_cpu_pkg::alu_add;
        imm_o           = {{20{ir_q[31]}}, ir_q[31:20]}; // i-type
        is_mem          = 1'b0;
        case (ir_q[6:0])
            rv_cpu_pkg::op_lui: begin
                ctrl_o.rs1_addr    = '0; // x0 + imm
                ctrl_o.alu_use_imm = 1'b1;
                ctrl_o.rf_we       = exec;
                imm_o              = {ir_q[31:12], 12'b0};
            end
            rv_cpu_pkg::op_imm: begin
                ctrl_o.alu_use_imm = 1'b1;
                ctrl_o.alu_op      = func_op;
                ctrl_o.rf_we       = exec && func_ok;
            end
            rv_cpu_pkg::op_reg: begin
                ctrl_o.alu_op = func_op;
                ctrl_o.rf_we  = exec && func_ok && reg_f7_ok;
            end
            rv_cpu_pkg::op_load: begin
                ctrl_o.alu_use_imm = 1'b1;
                ctrl_o.wb_sel      = rv_cpu_pkg::wb_mem;
                ctrl_o.lsu_re      = exec;
                ctrl_o.rf_we       = mem_done; // write in ack cycle
                is_mem             = 1'b1;
            end
            rv_cpu_pkg::op_store: begin
                ctrl_o.alu_use_imm = 1'b1;
                ctrl_o.lsu_we      = exec;
                imm_o              = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]}; // s-type
                is_mem             = 1'b1;
            end
            rv_cpu_pkg::op_branch: begin
                ctrl_o.alu_use_pc  = 1'b1; // pc + offset
                ctrl_o.alu_use_imm = 1'b1;
                imm_o = {{20{ir_q[31]}}, ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
            end
            rv_cpu_pkg::op_jal: begin
                ctrl_o.alu_use_pc  = 1'b1;
                ctrl_o.alu_use_imm = 1'b1;
                ctrl_o.wb_sel      = rv_cpu_pkg::wb_pc4;
                ctrl_o.rf_we       = exec;
                imm_o = {{12{ir_q[31]}}, ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
            end
            default: ; // no-op
        endcase
    end

    // next pc --------
    always_comb begin
        pc_nxt   = pc_q + 32'd4;
        jal_self = 1'b0;
        if (ir_q[6:0] == rv_cpu_pkg::op_jal) begin
            pc_nxt   = alu_add_i;
            jal_self = (alu_add_i == pc_q);
        end else if (ir_q[6:0] == rv_cpu_pkg::op_branch) begin
            if (((funct3 == 3'b000) && eq_i) || ((funct3 == 3'b001) && !eq_i)) begin
                pc_nxt = alu_add_i; // taken
            end
        end
    end

    // fsm --------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= rv_cpu_pkg::st_fetch;
            i_re_q  <= 1'b0;
            pc_q    <= cpu_boot_addr;
        end else begin
            case (state_q)
                rv_cpu_pkg::st_fetch: begin
                    if (!i_re_q) begin
                        i_re_q <= 1'b1; // first request after reset
                    end else if (i_bus_ack_i) begin
                        i_re_q  <= 1'b0;
                        state_q <= rv_cpu_pkg::st_execute;
                    end
                end
                rv_cpu_pkg::st_execute: begin
                    pc_q <= pc_nxt;
                    if (is_mem) begin
                        state_q <= rv_cpu_pkg::st_memory;
                    end else if (jal_self) begin
                        state_q <= rv_cpu_pkg::st_sleep;
                    end else begin
                        state_q <= rv_cpu_pkg::st_fetch;
                        i_re_q  <= 1'b1; // fetch next cycle
                    end
                end
                rv_cpu_pkg::st_memory: begin
                    if (!lsu_wait_i) begin
                        state_q <= rv_cpu_pkg::st_fetch;
                        i_re_q  <= 1'b1;
                    end
                end
                rv_cpu_pkg::st_sleep: ; // until reset
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == rv_cpu_pkg::st_fetch) && i_re_q && i_bus_ack_i) begin
            ir_q <= i_bus_rdata_i; // load in ack cycle
        end
    end

    assign i_bus_addr_o = pc_q;
    assign i_bus_re_o   = i_re_q;
    assign curr_pc_o    = pc_q;
    assign next_pc_o    = pc_q + 32'd4;
    assign sleep_o      = (state_q == rv_cpu_pkg::st_sleep);

endmodule

/* verilog/rv_cpu.sv */
// --------------------
// multi-cycle rv32i subset core, one instruction in flight
// both buses hold a request until ack, word accesses only
// --------------------
module rv_cpu #(
    parameter rv_cpu_pkg::word_t cpu_boot_addr = '0 // first fetch address
) (
    input  logic              clk_i,         // rising edge
    input  logic              reset_i,       // sync, active high
    output logic              sleep_o,       // parked after jal to self
    // instruction bus
    output rv_cpu_pkg::word_t i_bus_addr_o,
    input  rv_cpu_pkg::word_t i_bus_rdata_i,
    output logic              i_bus_re_o,
    input  logic              i_bus_ack_i,
    // data bus
    output rv_cpu_pkg::word_t d_bus_addr_o,
    input  rv_cpu_pkg::word_t d_bus_rdata_i,
    output rv_cpu_pkg::word_t d_bus_wdata_o,
    output logic              d_bus_we_o,
    output logic              d_bus_re_o,
    input  logic              d_bus_ack_i
);
    rv_cpu_pkg::ctrl_bus_t ctrl;      // main control bus
    rv_cpu_pkg::word_t     imm;       // decoded immediate
    rv_cpu_pkg::word_t     rs1;       // source operand 1
    rv_cpu_pkg::word_t     rs2;       // source operand 2, store data
    rv_cpu_pkg::word_t     alu_res;   // alu result
    rv_cpu_pkg::word_t     alu_add;   // address / target sum
    rv_cpu_pkg::word_t     mem_rdata; // load data
    rv_cpu_pkg::word_t     curr_pc;   // pc of current instr
    rv_cpu_pkg::word_t     next_pc;   // pc + 4
    logic                  alu_eq;    // rs1 == rs2
    logic                  lsu_wait;  // data access pending

    rv_cpu_control #(
        .cpu_boot_addr(cpu_boot_addr)
    ) rv_cpu_control_inst (
        .clk_i(clk_i), .reset_i(reset_i), .ctrl_o(ctrl),
        .i_bus_addr_o(i_bus_addr_o), .i_bus_rdata_i(i_bus_rdata_i),
        .i_bus_re_o(i_bus_re_o), .i_bus_ack_i(i_bus_ack_i),
        .eq_i(alu_eq), .alu_add_i(alu_add), .lsu_wait_i(lsu_wait),
        .imm_o(imm), .curr_pc_o(curr_pc), .next_pc_o(next_pc), .sleep_o(sleep_o)
    );

    rv_cpu_regfile rv_cpu_regfile_inst (
        .clk_i(clk_i), .ctrl_i(ctrl), .alu_i(alu_res), .mem_i(mem_rdata),
        .pc4_i(next_pc), .rs1_o(rs1), .rs2_o(rs2)
    );

    rv_cpu_alu rv_cpu_alu_inst (
        .ctrl_i(ctrl), .rs1_i(rs1), .rs2_i(rs2), .pc_i(curr_pc), .imm_i(imm),
        .res_o(alu_res), .add_o(alu_add), .eq_o(alu_eq)
    );

    rv_cpu_lsu rv_cpu_lsu_inst (
        .clk_i(clk_i), .reset_i(reset_i), .ctrl_i(ctrl), .addr_i(alu_add),
        .wdata_i(rs2), .rdata_o(mem_rdata), .wait_o(lsu_wait),
        .d_bus_addr_o(d_bus_addr_o), .d_bus_rdata_i(d_bus_rdata_i),
        .d_bus_wdata_o(d_bus_wdata_o), .d_bus_we_o(d_bus_we_o),
        .d_bus_re_o(d_bus_re_o), .d_bus_ack_i(d_bus_ack_i)
    );

endmodule

/* verif/tb_rv_cpu_checker.sv */
// --------------------
// checks data-bus stores in order, one store per ack cycle
// any store after sleep_o counts as an error
// --------------------
module tb_rv_cpu_checker (
    input logic        clk_i,
    input logic        reset_i,
    input logic        sleep_i,   // dut parked
    input logic        d_we_i,
    input logic        d_ack_i,
    input logic [31:0] d_addr_i,
    input logic [31:0] d_wdata_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] exp_addr_q[$]; // pending expected stores
    logic [31:0] exp_data_q[$];
    string       test_name;
    int          error_count = 0;
    int          check_count = 0;
    int          store_idx;     // stores seen in this test

    task automatic start_test(input string name);
        test_name = name;
        store_idx = 0;
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic end_test();
        if (exp_addr_q.size() != 0) begin
            $display("%s: %0d expected store(s) never happened", test_name, exp_addr_q.size());
            error_count++;
        end
    endtask

    // store monitor --------
    always @(posedge clk_i) begin
        logic [31:0] ea;
        logic [31:0] ed;
        if (!reset_i && d_we_i && d_ack_i) begin
            check_count++;
            if (sleep_i) begin
                $display("%s: store to %h after sleep_o was set", test_name, d_addr_i);
                error_count++;
            end else if (exp_addr_q.size() == 0) begin
                $display("%s: extra store to %h data %h", test_name, d_addr_i, d_wdata_i);
                error_count++;
            end else begin
                ea = exp_addr_q.pop_front();
                ed = exp_data_q.pop_front();
                if (ea != d_addr_i || ed != d_wdata_i) begin
                    $display("Error %s store %0d: expected %h:%h actual %h:%h",
                             test_name, store_idx, ea, ed, d_addr_i, d_wdata_i);
                    error_count++;
                end
            end
            store_idx++;
        end
    end

endmodule

/* verif/tb_rv_cpu.sv */
// --------------------
// each program runs twice with zero ack delay then lfsr delays
// programs sit at address 0 and end with jal x0, 0
// --------------------
module tb_rv_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_tests       = 5;
    localparam int watchdog_cycles = 200 * num_tests * 2; // two passes

    logic        clk_i;
    logic        reset_i;
    logic        sleep_o;
    logic [31:0] i_bus_addr_o;
    logic [31:0] i_bus_rdata_i;
    logic [31:0] d_bus_addr_o;
    logic [31:0] d_bus_rdata_i;
    logic [31:0] d_bus_wdata_o;
    logic        i_bus_re_o;
    logic        i_bus_ack_i;
    logic        d_bus_we_o;
    logic        d_bus_re_o;
    logic        d_bus_ack_i;

    string       test_name [num_tests];
    logic [31:0] prog_mem  [num_tests][16];
    int          prog_len  [num_tests];
    logic [31:0] exp_addr  [num_tests][8];
    logic [31:0] exp_data  [num_tests][8];
    int          exp_len   [num_tests];
    logic [31:0] imem [16];   // instruction memory model
    logic [31:0] dmem [1024]; // data memory model
    logic [31:0] lfsr = 32'hafda;
    int          i_wait;         // idle cycles before next fetch ack
    int          d_wait;         // idle cycles before next data ack
    int          cur;            // table row being built
    bit          use_delay;

    rv_cpu rv_cpu_inst (.*);

    tb_rv_cpu_checker checker_inst (
        .clk_i(clk_i), .reset_i(reset_i), .sleep_i(sleep_o), .d_we_i(d_bus_we_o),
        .d_ack_i(d_bus_ack_i), .d_addr_i(d_bus_addr_o), .d_wdata_i(d_bus_wdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i; // 8 ns
    end

    // instruction encoders --------
    function automatic logic [31:0] enc_i(int op, int rd, int f3, int rs1, int imm);
        return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
    endfunction
    function automatic logic [31:0] enc_r(int f7, int rd, int f3, int rs1, int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction
    function automatic logic [31:0] enc_sw(int rs2, int rs1, int imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'h23};
    endfunction
    function automatic logic [31:0] enc_b(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
    endfunction
    function automatic logic [31:0] enc_jal(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic put(input logic [31:0] w);
        prog_mem[cur][prog_len[cur]] = w;
        prog_len[cur]++;
    endtask
    task automatic store(input logic [31:0] a, input logic [31:0] d);
        exp_addr[cur][exp_len[cur]] = a;
        exp_data[cur][exp_len[cur]] = d;
        exp_len[cur]++;
    endtask
    task automatic new_test(input int t, input string name);
        cur = t;
        test_name[t] = name;
        prog_len[t] = 0;
        exp_len[t] = 0;
    endtask

    // program table --------
    task automatic build_table();
        new_test(0, "imm_ops");
        put({20'h12345, 5'd1, 7'h37});                   // lui x1
        put(enc_i('h13, 2, 0, 1, -1));                   // addi x2, x1, -1
        put(enc_i('h13, 3, 7, 2, 'h0f0));                // andi
        put(enc_i('h13, 4, 6, 0, 'h555));                // ori
        put(enc_i('h13, 5, 4, 4, -1));                   // xori as not
        put(enc_i('h13, 6, 2, 5, 0));                    // slti neg < 0
        for (int r = 1; r <= 6; r++) put(enc_sw(r, 0, 'h100 + 4 * (r - 1)));
        store(32'h100, 32'h12345000);
        store(32'h104, 32'h12344fff);
        store(32'h108, 32'h000000f0);
        store(32'h10c, 32'h00000555);
        store(32'h110, 32'hfffffaaa);
        store(32'h114, 32'h00000001);
        new_test(1, "reg_ops");
        put(enc_i('h13, 1, 0, 0, 5));
        put(enc_i('h13, 2, 0, 0, 9));
        put(enc_r(0, 3, 0, 1, 2));                       // add
        put(enc_r('h20, 4, 0, 1, 2));                    // sub with negative result
        put(enc_r(0, 5, 7, 1, 2));                       // and
        put(enc_r(0, 6, 6, 1, 2));                       // or
        put(enc_r(0, 7, 4, 1, 2));                       // xor
        put(enc_r(0, 8, 2, 4, 1));                       // slt -4 < 5
        for (int r = 3; r <= 8; r++) put(enc_sw(r, 0, 'h200 + 4 * (r - 3)));
        store(32'h200, 32'd14);
        store(32'h204, 32'hfffffffc);
        store(32'h208, 32'd1);
        store(32'h20c, 32'd13);
        store(32'h210, 32'd12);
        store(32'h214, 32'd1);
        new_test(2, "load_store");
        put(enc_i('h13, 1, 0, 0, 'h077));
        put(enc_sw(1, 0, 'h300));
        put(enc_i('h03, 2, 2, 0, 'h300));                // lw
        put(enc_i('h13, 3, 0, 2, 'h010));
        put(enc_sw(3, 0, 'h304));
        put(enc_r(0, 0, 0, 1, 1));                       // add x0 is dropped
        put(enc_sw(0, 0, 'h308));
        store(32'h300, 32'h77);
        store(32'h304, 32'h87);
        store(32'h308, 32'h0);
        new_test(3, "branches");
        put(enc_i('h13, 1, 0, 0, 3));
        put(enc_i('h13, 2, 0, 0, 3));
        put(enc_b(0, 1, 2, 8));                          // beq taken
        put(enc_sw(0, 0, 'h404));                        // skipped
        put(enc_b(1, 1, 2, 8));                          // bne not taken
        put(enc_sw(2, 0, 'h400));
        put(enc_sw(1, 0, 'h408));                        // loop body
        put(enc_i('h13, 1, 0, 1, -1));
        put(enc_b(1, 1, 0, -8));                         // countdown
        store(32'h400, 32'd3);
        store(32'h408, 32'd3);
        store(32'h408, 32'd2);
        store(32'h408, 32'd1);
        new_test(4, "jal");
        put(enc_jal(1, 8));                              // x1 = 4
        put(enc_sw(0, 0, 'h5f0));                        // skipped
        put(enc_sw(1, 0, 'h500));
        put(enc_jal(2, 8));                              // x2 = 16
        put(enc_sw(0, 0, 'h5f4));                        // skipped
        put(enc_sw(2, 0, 'h504));
        store(32'h500, 32'd4);
        store(32'h504, 32'd16);
        for (int t = 0; t < num_tests; t++) begin
            cur = t;
            put(enc_jal(0, 0));                          // park
        end
    endtask

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per delay bit
    task automatic draw_delay(output int d);
        d = 0;
        if (use_delay) begin
            repeat (2) begin
                d = (d << 1) | int'(lfsr[0]);
                lfsr = lfsr_next(lfsr);
            end
        end
    endtask

    // bus memory models driven on the falling edge --------
    always @(negedge clk_i) begin
        if (reset_i || i_bus_ack_i) begin
            i_bus_ack_i = 1'b0; // request consumed
            draw_delay(i_wait);
        end else if (i_bus_re_o) begin
            if (i_wait == 0) begin
                i_bus_ack_i   = 1'b1;
                i_bus_rdata_i = imem[i_bus_addr_o[5:2]];
            end else i_wait--;
        end
        if (reset_i || d_bus_ack_i) begin
            d_bus_ack_i = 1'b0;
            draw_delay(d_wait);
        end else if (d_bus_re_o || d_bus_we_o) begin
            if (d_wait == 0) begin
                d_bus_ack_i   = 1'b1;
                d_bus_rdata_i = dmem[d_bus_addr_o[11:2]];
                if (d_bus_we_o) dmem[d_bus_addr_o[11:2]] = d_bus_wdata_o;
            end else d_wait--;
        end
    end

    task automatic run_test(input int t);
        @(negedge clk_i);
        reset_i <= 1'b1;
        for (int i = 0; i < 16; i++) imem[i] = (i < prog_len[t]) ? prog_mem[t][i] : 32'h13;
        for (int i = 0; i < 1024; i++) dmem[i] = 32'hdead0000 ^ (32'(i) << 2);
        checker_inst.start_test($sformatf("%s/%s", test_name[t], use_delay ? "delay" : "nodelay"));
        for (int i = 0; i < exp_len[t]; i++) checker_inst.expect_store(exp_addr[t][i], exp_data[t][i]);
        repeat (5) @(negedge clk_i);
        reset_i <= 1'b0;
        while (!sleep_o) @(negedge clk_i);
        repeat (10) @(negedge clk_i); // any late store shows here
        checker_inst.end_test();
    endtask

    initial begin
        reset_i       = 1'b1;
        i_bus_ack_i   = 1'b0;
        d_bus_ack_i   = 1'b0;
        i_bus_rdata_i = '0;
        d_bus_rdata_i = '0;
        use_delay     = 1'b0;
        build_table();
        for (int p = 0; p < 2; p++) begin
            use_delay = (p == 1); // back-pressure pass
            for (int t = 0; t < num_tests; t++) run_test(t);
        end
        $display("errors: %0d, stores checked: %0d",
                 checker_inst.error_count, checker_inst.check_count);
        if (checker_inst.error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog --------
    initial begin
        #(watchdog_cycles * 8);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* compile.f */
verilog/rv_cpu_pkg.sv
verilog/rv_cpu_regfile.sv
verilog/rv_cpu_alu.sv
verilog/rv_cpu_lsu.sv
verilog/rv_cpu_control.sv
verilog/rv_cpu.sv
verif/tb_rv_cpu_checker.sv
verif/tb_rv_cpu.sv

/* Makefile */
SIM := obj_dir/Vtb_rv_cpu

all: run

$(SIM): compile.f $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing -j 0 -f compile.f --top-module tb_rv_cpu -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
